// ==== project.f ====
common/eth_rx_pkg.sv
gmii_rx/gmii_rx_fsm.sv
gmii_rx/gmii_rx_datapath.sv
logic/mcf_rx_parser.sv
logic/pause_quanta_timer.sv
logic/eth_mac_rx_top.sv
verif/eth_mac_rx_props.sv
verif/eth_mac_rx_tb.sv

// ==== Bender.yml ====
package:
  name: eth_mac_rx

sources:
  # shared package first, then the blocks, then the top level
  - common/eth_rx_pkg.sv
  - gmii_rx/gmii_rx_fsm.sv
  - gmii_rx/gmii_rx_datapath.sv
  - logic/mcf_rx_parser.sv
  - logic/pause_quanta_timer.sv
  - logic/eth_mac_rx_top.sv

  - target: simulation
    files:
      - verif/eth_mac_rx_props.sv
      - verif/eth_mac_rx_tb.sv

// ==== verif/eth_mac_rx_tb.sv ====
// Testbench for the Ethernet receive MAC
// Sends GMII frames with a software FCS and checks the byte stream, the
// error pulses and the PAUSE request handling against expected values

`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx_tb;

    localparam int cpq = 4;
    localparam eth_rx_pkg::mac_addr_t own_mac = 48'h02_12_34_56_78_9a;
    localparam int c_fcs  = 0;
    localparam int c_bad  = 1;
    localparam int c_mcf  = 2;
    localparam int c_pkt  = 3;
    localparam int c_xon  = 4;
    localparam int c_xoff = 5;
    localparam int c_rise = 6;

    logic                  rx_clk = 1'b0;
    logic                  rx_rst;
    eth_rx_pkg::byte_t     gmii_rxd;
    logic                  gmii_rx_dv;
    logic                  gmii_rx_er;
    eth_rx_pkg::rx_beat_t  rx_axis;
    logic                  rx_error_bad_frame;
    logic                  rx_error_bad_fcs;
    eth_rx_pkg::mac_addr_t cfg_mcf_eth_dst_ucast;
    logic                  cfg_mcf_check_eth_dst_ucast;
    logic                  rx_lfc_en;
    logic                  rx_lfc_req;
    logic                  rx_lfc_ack;
    logic                  stat_rx_mcf;
    logic                  stat_rx_lfc_pkt;
    logic                  stat_rx_lfc_xon;
    logic                  stat_rx_lfc_xoff;
    logic                  stat_rx_lfc_paused;

    eth_rx_pkg::byte_t    pay_q[$];  // payload of the frame being sent, without FCS
    eth_rx_pkg::rx_beat_t beat_q[$];
    logic [15:0]          lfsr = 16'd91;
    int                   cnt [0:6];
    int                   snap [0:6];
    int                   frame_cnt = 0;
    int                   frames_sent = 0;
    int                   cycle = 0;
    int                   xon_cycle = 0;
    int                   fall_cycle = 0;
    logic                 req_prev = 1'b0;
    int                   errors = 0;
    int                   tests = 0;

    eth_mac_rx_top #(
        .cycles_per_quanta (cpq)
    ) dut (
        .rx_clk                      (rx_clk),
        .rx_rst                      (rx_rst),
        .gmii_rxd                    (gmii_rxd),
        .gmii_rx_dv                  (gmii_rx_dv),
        .gmii_rx_er                  (gmii_rx_er),
        .rx_axis                     (rx_axis),
        .rx_error_bad_frame          (rx_error_bad_frame),
        .rx_error_bad_fcs            (rx_error_bad_fcs),
        .cfg_mcf_eth_dst_ucast       (cfg_mcf_eth_dst_ucast),
        .cfg_mcf_check_eth_dst_ucast (cfg_mcf_check_eth_dst_ucast),
        .rx_lfc_en                   (rx_lfc_en),
        .rx_lfc_req                  (rx_lfc_req),
        .rx_lfc_ack                  (rx_lfc_ack),
        .stat_rx_mcf                 (stat_rx_mcf),
        .stat_rx_lfc_pkt             (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon             (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff            (stat_rx_lfc_xoff),
        .stat_rx_lfc_paused          (stat_rx_lfc_paused)
    );

    always #50 rx_clk = ~rx_clk;

    // outputs settle after the rising edge, so the monitor looks at the falling one
    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            cycle = cycle + 1;
            if (rx_axis.valid) begin
                beat_q.push_back(rx_axis);
                frame_cnt = frame_cnt + (rx_axis.last ? 1 : 0);
            end
            cnt[c_fcs]  = cnt[c_fcs] + (rx_error_bad_fcs ? 1 : 0);
            cnt[c_bad]  = cnt[c_bad] + (rx_error_bad_frame ? 1 : 0);
            cnt[c_mcf]  = cnt[c_mcf] + (stat_rx_mcf ? 1 : 0);
            cnt[c_pkt]  = cnt[c_pkt] + (stat_rx_lfc_pkt ? 1 : 0);
            cnt[c_xon]  = cnt[c_xon] + (stat_rx_lfc_xon ? 1 : 0);
            cnt[c_xoff] = cnt[c_xoff] + (stat_rx_lfc_xoff ? 1 : 0);
            cnt[c_rise] = cnt[c_rise] + ((rx_lfc_req && !req_prev) ? 1 : 0);
            if (stat_rx_lfc_xon) begin
                xon_cycle = cycle;
            end
            if (!rx_lfc_req && req_prev) begin
                fall_cycle = cycle;
            end
            req_prev = rx_lfc_req;
        end
    end

    // Galois LFSR that takes one step per random bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // wire-order FCS from a bit-serial reflected CRC-32
    function automatic logic [31:0] fcs_of(input eth_rx_pkg::byte_t data[$]);
        logic [31:0] r;
        logic        fb;
        r = 32'hffffffff;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ data[i][b];
                r  = {1'b0, r[31:1]} ^ (fb ? eth_rx_pkg::crc32_poly_rev : 32'h0);
            end
        end
        return ~r;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("check failed at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic drive_byte(input eth_rx_pkg::byte_t b, input logic er);
        @(posedge rx_clk);
        #5;
        gmii_rxd   = b;
        gmii_rx_dv = 1'b1;
        gmii_rx_er = er;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge rx_clk);
            #5;
            gmii_rxd   = 8'h00;
            gmii_rx_dv = 1'b0;
            gmii_rx_er = 1'b0;
        end
    endtask

    // preamble, SFD, payload, FCS least significant byte first, then an idle gap
    task automatic send_frame(input logic [31:0] fcs_flip, input int er_pos);
        logic [31:0] fcs;
        fcs = fcs_of(pay_q) ^ fcs_flip;
        repeat (7) drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
        drive_byte(eth_rx_pkg::sfd_byte, 1'b0);
        foreach (pay_q[i]) begin
            drive_byte(pay_q[i], i == er_pos);
        end
        for (int i = 0; i < 4; i++) begin
            drive_byte(fcs[8*i +: 8], 1'b0);
        end
        idle(12);
        frames_sent++;
    endtask

    task automatic wait_frames();
        int t;
        t = 0;
        while (frame_cnt < frames_sent) begin
            @(posedge rx_clk);
            #5;
            t++;
            if (t > 300) begin
                give_up("the last beat of a frame on rx_axis");
            end
        end
    endtask

    task automatic wait_req_high();
        int t;
        t = 0;
        while (!rx_lfc_req) begin
            @(negedge rx_clk);
            t++;
            if (t > 50) begin
                give_up("rx_lfc_req to rise");
            end
        end
    endtask

    task automatic make_random(input int len);
        pay_q.delete();
        repeat (len) pay_q.push_back(rand_bits(8));
    endtask

    task automatic make_pause(input eth_rx_pkg::mac_addr_t dst, input logic [15:0] etype,
                              input logic [15:0] quanta);
        logic [15:0] op;
        op = 16'(eth_rx_pkg::opcode_pause);
        pay_q.delete();
        for (int i = 5; i >= 0; i--) begin
            pay_q.push_back(dst[8*i +: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            pay_q.push_back(8'h20 + 8'(i)); // source address
        end
        pay_q.push_back(etype[15:8]);
        pay_q.push_back(etype[7:0]);
        pay_q.push_back(op[15:8]);
        pay_q.push_back(op[7:0]);
        pay_q.push_back(quanta[15:8]);
        pay_q.push_back(quanta[7:0]);
        while (pay_q.size() < 60) begin
            pay_q.push_back(8'h00); // pad up to the minimum frame
        end
    endtask

    task automatic check_frame(input logic exp_user);
        int n;
        n = pay_q.size();
        expect_equal("rx_axis beat count", n, beat_q.size());
        for (int i = 0; i < n && i < beat_q.size(); i++) begin
            expect_equal("rx_axis.data", pay_q[i], beat_q[i].data);
            expect_equal("rx_axis.last", i == n - 1, beat_q[i].last);
            expect_equal("rx_axis.user", (i == n - 1) ? exp_user : 1'b0, beat_q[i].user);
        end
        beat_q.delete();
    endtask

    task automatic check_abort();
        int n;
        n = beat_q.size();
        expect_true(n > 0, "aborted frame gave no beats");
        for (int i = 0; i < n; i++) begin
            expect_equal("rx_axis.last", i == n - 1, beat_q[i].last);
        end
        if (n > 0) begin
            expect_equal("rx_axis.user", 1'b1, beat_q[n-1].user);
        end
        beat_q.delete();
    endtask

    task automatic expect_delta(input string name, input int idx, input int exp);
        expect_equal(name, exp, cnt[idx] - snap[idx]);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: done with %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        int err0;
        int n_ack;
        int t;
        foreach (cnt[i]) cnt[i] = 0;
        rx_rst                      = 1'b1;
        gmii_rxd                    = 8'h00;
        gmii_rx_dv                  = 1'b0;
        gmii_rx_er                  = 1'b0;
        cfg_mcf_eth_dst_ucast       = own_mac;
        cfg_mcf_check_eth_dst_ucast = 1'b1;
        rx_lfc_en                   = 1'b1;
        rx_lfc_ack                  = 1'b1;
        repeat (16) @(posedge rx_clk);
        #5;
        rx_rst = 1'b0;
        idle(4);

        err0 = errors;
        snap = cnt;
        repeat (5) begin
            make_random(20 + int'(rand_bits(6)) % 41);
            send_frame(32'h0, -1);
            wait_frames();
            check_frame(1'b0);
        end
        expect_delta("rx_error_bad_fcs pulses", c_fcs, 0);
        expect_delta("rx_error_bad_frame pulses", c_bad, 0);
        finish_test("good frames", err0);

        err0 = errors;
        snap = cnt;
        make_random(33);
        send_frame(32'h0000_0400, -1);
        wait_frames();
        check_frame(1'b1);
        expect_delta("rx_error_bad_fcs pulses", c_fcs, 1);
        expect_delta("rx_error_bad_frame pulses", c_bad, 0);
        finish_test("corrupted FCS", err0);

        err0 = errors;
        snap = cnt;
        make_random(40);
        send_frame(32'h0, 10);
        wait_frames();
        check_abort();
        expect_delta("rx_error_bad_frame pulses", c_bad, 1);
        make_random(24);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        finish_test("gmii_rx_er in payload", err0);

        err0 = errors;
        snap = cnt;
        rx_lfc_ack = 1'b0; // hold the timer so the pause length can be measured
        make_pause(own_mac, eth_rx_pkg::mcf_eth_type, 16'd5);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        expect_delta("stat_rx_mcf pulses", c_mcf, 1);
        expect_delta("stat_rx_lfc_pkt pulses", c_pkt, 1);
        expect_delta("stat_rx_lfc_xoff pulses", c_xoff, 1);
        wait_req_high();
        repeat (8) begin
            @(negedge rx_clk);
            expect_equal("rx_lfc_req", 1'b1, rx_lfc_req);
            expect_equal("stat_rx_lfc_paused", 1'b0, stat_rx_lfc_paused);
        end
        expect_delta("rx_lfc_req rises", c_rise, 1);
        n_ack = 0;
        t     = 0;
        while (rx_lfc_req) begin
            @(posedge rx_clk);
            #5;
            rx_lfc_ack = 1'b1;
            @(negedge rx_clk);
            if (rx_lfc_req) begin
                n_ack = n_ack + 1;
                expect_equal("stat_rx_lfc_paused", 1'b1, stat_rx_lfc_paused);
            end
            t++;
            if (t > 200) begin
                give_up("rx_lfc_req to fall");
            end
        end
        expect_equal("acknowledged rx_lfc_req cycles", 5 * cpq, n_ack);
        finish_test("PAUSE frame", err0);

        err0 = errors;
        snap = cnt;
        make_pause(own_mac ^ 48'h1, eth_rx_pkg::mcf_eth_type, 16'd9);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        expect_delta("stat_rx_mcf pulses", c_mcf, 1);
        expect_delta("stat_rx_lfc_pkt pulses", c_pkt, 0);
        expect_delta("rx_lfc_req rises", c_rise, 0);
        snap = cnt;
        make_pause(own_mac, 16'h0800, 16'd9);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        expect_delta("stat_rx_mcf pulses", c_mcf, 0);
        expect_delta("stat_rx_lfc_pkt pulses", c_pkt, 0);
        expect_delta("rx_lfc_req rises", c_rise, 0);
        expect_equal("rx_lfc_req", 1'b0, rx_lfc_req);
        finish_test("rejected control frames", err0);

        err0 = errors;
        rx_lfc_ack = 1'b0;
        make_pause(own_mac, eth_rx_pkg::mcf_eth_type, 16'd100);
        send_frame(32'h0, -1);
        wait_frames();
        beat_q.delete();
        wait_req_high();
        snap = cnt;
        make_pause(own_mac, eth_rx_pkg::mcf_eth_type, 16'd0);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        expect_delta("stat_rx_lfc_xon pulses", c_xon, 1);
        expect_equal("rx_lfc_req", 1'b0, rx_lfc_req);
        expect_true(fall_cycle >= xon_cycle && fall_cycle - xon_cycle <= 2,
                    "rx_lfc_req did not drop soon after XON");
        rx_lfc_en = 1'b0;
        snap      = cnt;
        make_pause(own_mac, eth_rx_pkg::mcf_eth_type, 16'd7);
        send_frame(32'h0, -1);
        wait_frames();
        check_frame(1'b0);
        expect_delta("stat_rx_lfc_pkt pulses", c_pkt, 1);
        expect_delta("rx_lfc_req rises", c_rise, 0);
        expect_equal("rx_lfc_req", 1'b0, rx_lfc_req);
        rx_lfc_en  = 1'b1;
        rx_lfc_ack = 1'b1;
        finish_test("XON and disabled pause", err0);

        idle(4);
        errors = errors + dut.u_props.fail_cnt;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/eth_mac_rx_props.sv ====
// Receive MAC properties
// Concurrent checks on error pulses, the pause request and reset behavior,
// bound into the receive MAC top level

`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx_props (
    input wire logic                 rx_clk,
    input wire logic                 rx_rst,
    input wire eth_rx_pkg::rx_beat_t rx_axis,
    input wire logic                 rx_error_bad_frame,
    input wire logic                 rx_error_bad_fcs,
    input wire logic                 rx_lfc_req,
    input wire logic                 stat_rx_mcf,
    input wire logic                 stat_rx_lfc_pkt,
    input wire logic                 stat_rx_lfc_xon,
    input wire logic                 stat_rx_lfc_xoff,
    input wire logic                 stat_rx_lfc_paused
);

    int fail_cnt = 0;

    // an error pulse always rides on the flagged last beat of its frame
    err_on_last_beat: assert property (@(posedge rx_clk) disable iff (rx_rst)
        (rx_error_bad_fcs || rx_error_bad_frame) |->
            (rx_axis.valid && rx_axis.last && rx_axis.user))
    else begin
        fail_cnt++;
        $error("error pulse without a valid last beat carrying user");
    end

    req_after_pkt: assert property (@(posedge rx_clk) disable iff (rx_rst)
        $rose(rx_lfc_req) |-> $past(stat_rx_lfc_pkt))
    else begin
        fail_cnt++;
        $error("rx_lfc_req rose without a PAUSE frame in the cycle before");
    end

    quiet_in_reset: assert property (@(posedge rx_clk)
        rx_rst |-> !(rx_axis.valid || rx_error_bad_frame || rx_error_bad_fcs || rx_lfc_req ||
                     stat_rx_mcf || stat_rx_lfc_pkt || stat_rx_lfc_xon ||
                     stat_rx_lfc_xoff || stat_rx_lfc_paused))
    else begin
        fail_cnt++;
        $error("an output is active during reset");
    end

endmodule

bind eth_mac_rx_top eth_mac_rx_props u_props (
    .rx_clk             (rx_clk),
    .rx_rst             (rx_rst),
    .rx_axis            (rx_axis),
    .rx_error_bad_frame (rx_error_bad_frame),
    .rx_error_bad_fcs   (rx_error_bad_fcs),
    .rx_lfc_req         (rx_lfc_req),
    .stat_rx_mcf        (stat_rx_mcf),
    .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
    .stat_rx_lfc_xon    (stat_rx_lfc_xon),
    .stat_rx_lfc_xoff   (stat_rx_lfc_xoff),
    .stat_rx_lfc_paused (stat_rx_lfc_paused)
);

`default_nettype wire

// ==== logic/eth_mac_rx_top.sv ====
// 1G Ethernet receive MAC
// Samples the GMII pins, recovers frames into a byte stream and handles
// link-level PAUSE frames through the rx_lfc_req/rx_lfc_ack pair

`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx_top #(
    parameter int cycles_per_quanta = 64
) (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire eth_rx_pkg::byte_t     gmii_rxd,
    input  wire logic                  gmii_rx_dv,
    input  wire logic                  gmii_rx_er,
    output eth_rx_pkg::rx_beat_t       rx_axis,
    output logic                       rx_error_bad_frame,
    output logic                       rx_error_bad_fcs,
    input  wire eth_rx_pkg::mac_addr_t cfg_mcf_eth_dst_ucast,
    input  wire logic                  cfg_mcf_check_eth_dst_ucast,
    input  wire logic                  rx_lfc_en,
    output logic                       rx_lfc_req,
    input  wire logic                  rx_lfc_ack,
    output logic                       stat_rx_mcf,
    output logic                       stat_rx_lfc_pkt,
    output logic                       stat_rx_lfc_xon,
    output logic                       stat_rx_lfc_xoff,
    output logic                       stat_rx_lfc_paused
);

    eth_rx_pkg::gmii_rx_t   gmii_q;
    eth_rx_pkg::rx_ctrl_t   rx_ctrl;
    eth_rx_pkg::pause_cmd_t pause_cmd;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            gmii_q <= '0;
        end else begin
            gmii_q <= '{rxd: gmii_rxd, dv: gmii_rx_dv, er: gmii_rx_er}; // input flop stage
        end
    end

    gmii_rx_fsm u_fsm (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .gmii      (gmii_q),
        .ctrl      (rx_ctrl),
        .bad_frame (rx_error_bad_frame)
    );

    gmii_rx_datapath u_datapath (
        .rx_clk  (rx_clk),
        .rx_rst  (rx_rst),
        .gmii    (gmii_q),
        .ctrl    (rx_ctrl),
        .beat    (rx_axis),
        .bad_fcs (rx_error_bad_fcs)
    );

    mcf_rx_parser u_parser (
        .rx_clk                      (rx_clk),
        .rx_rst                      (rx_rst),
        .beat                        (rx_axis),
        .cfg_mcf_eth_dst_ucast       (cfg_mcf_eth_dst_ucast),
        .cfg_mcf_check_eth_dst_ucast (cfg_mcf_check_eth_dst_ucast),
        .rx_lfc_en                   (rx_lfc_en),
        .cmd                         (pause_cmd),
        .stat_rx_mcf                 (stat_rx_mcf),
        .stat_rx_lfc_pkt             (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon             (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff            (stat_rx_lfc_xoff)
    );

    pause_quanta_timer #(
        .cycles_per_quanta (cycles_per_quanta)
    ) u_timer (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .cmd                (pause_cmd),
        .rx_lfc_ack         (rx_lfc_ack),
        .rx_lfc_req         (rx_lfc_req),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

endmodule

`default_nettype wire

// ==== logic/pause_quanta_timer.sv ====
// Receive pause quanta timer
// Keeps rx_lfc_req up for quanta times cycles_per_quanta acknowledged cycles

`timescale 1ns/1ps
`default_nettype none

module pause_quanta_timer #(
    parameter int cycles_per_quanta = 64
) (
    input  wire logic                   rx_clk,
    input  wire logic                   rx_rst,
    input  wire eth_rx_pkg::pause_cmd_t cmd,
    input  wire logic                   rx_lfc_ack,
    output logic                        rx_lfc_req,
    output logic                        stat_rx_lfc_paused
);

    localparam int cyc_w = (cycles_per_quanta > 1) ? $clog2(cycles_per_quanta) : 1;

    logic [15:0]      quanta_cnt;
    logic [cyc_w-1:0] cyc_cnt;    // position inside the current quantum

    assign rx_lfc_req         = (quanta_cnt != 16'd0);
    assign stat_rx_lfc_paused = rx_lfc_req && rx_lfc_ack;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt <= '0;
            cyc_cnt    <= '0;
        end else if (cmd.valid) begin
            quanta_cnt <= cmd.quanta; // zero quanta is XON and ends the pause
            cyc_cnt    <= '0;
        end else if (rx_lfc_req && rx_lfc_ack) begin
            if (cyc_cnt == cyc_w'(cycles_per_quanta - 1)) begin
                cyc_cnt    <= '0;
                quanta_cnt <= quanta_cnt - 16'd1;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mcf_rx_parser.sv ====
// MAC control frame parser
// Picks destination, EtherType, opcode and quanta out of the receive stream
// and turns good PAUSE frames into pause commands and status pulses

`timescale 1ns/1ps
`default_nettype none

module mcf_rx_parser (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire eth_rx_pkg::rx_beat_t  beat,
    input  wire eth_rx_pkg::mac_addr_t cfg_mcf_eth_dst_ucast,
    input  wire logic                  cfg_mcf_check_eth_dst_ucast,
    input  wire logic                  rx_lfc_en,
    output eth_rx_pkg::pause_cmd_t     cmd,
    output logic                       stat_rx_mcf,
    output logic                       stat_rx_lfc_pkt,
    output logic                       stat_rx_lfc_xon,
    output logic                       stat_rx_lfc_xoff
);

    logic [4:0]            pos;        // byte index within the frame, sticks at 31
    eth_rx_pkg::mac_addr_t eth_dst;
    logic [15:0]           eth_type;
    logic [15:0]           opcode;
    logic [15:0]           quanta;
    logic [15:0]           quanta_cur;
    logic                  frame_done;
    logic                  is_mcf;
    logic                  dst_ok;
    logic                  is_lfc;

    // an 18-byte frame ends on the low quanta byte, which is still on the bus
    assign quanta_cur = (pos == 5'd17) ? {quanta[7:0], beat.data} : quanta;

    assign frame_done = beat.valid && beat.last && !beat.user && (pos >= 5'd17);
    assign is_mcf     = (eth_type == eth_rx_pkg::mcf_eth_type);
    assign dst_ok     = !cfg_mcf_check_eth_dst_ucast || (eth_dst == cfg_mcf_eth_dst_ucast);
    assign is_lfc     = is_mcf && dst_ok && (opcode == 16'(eth_rx_pkg::opcode_pause));

    always_ff @(posedge rx_clk) begin
        if (beat.valid) begin
            if (pos < 5'd6) begin
                eth_dst <= {eth_dst[39:0], beat.data}; // big-endian, first byte ends up on top
            end
            if (pos == 5'd12 || pos == 5'd13) begin
                eth_type <= {eth_type[7:0], beat.data};
            end
            if (pos == 5'd14 || pos == 5'd15) begin
                opcode <= {opcode[7:0], beat.data};
            end
            if (pos == 5'd16 || pos == 5'd17) begin
                quanta <= {quanta[7:0], beat.data};
            end
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            pos              <= '0;
            cmd              <= '0;
            stat_rx_mcf      <= 1'b0;
            stat_rx_lfc_pkt  <= 1'b0;
            stat_rx_lfc_xon  <= 1'b0;
            stat_rx_lfc_xoff <= 1'b0;
        end else begin
            cmd.valid        <= 1'b0;
            stat_rx_mcf      <= 1'b0;
            stat_rx_lfc_pkt  <= 1'b0;
            stat_rx_lfc_xon  <= 1'b0;
            stat_rx_lfc_xoff <= 1'b0;
            if (beat.valid) begin
                if (beat.last) begin
                    pos <= '0;
                end else if (pos != 5'd31) begin
                    pos <= pos + 5'd1;
                end
            end
            if (frame_done) begin
                stat_rx_mcf      <= is_mcf;
                stat_rx_lfc_pkt  <= is_lfc;
                stat_rx_lfc_xon  <= is_lfc && (quanta_cur == 16'd0);
                stat_rx_lfc_xoff <= is_lfc && (quanta_cur != 16'd0);
                cmd.valid        <= is_lfc && rx_lfc_en;
                cmd.quanta       <= quanta_cur;
            end
        end
    end

endmodule

`default_nettype wire

// ==== gmii_rx/gmii_rx_datapath.sv ====
// GMII receive datapath
// Runs the CRC-32 over payload and FCS, keeps the FCS inside a 4-byte delay
// line and holds one byte back so the frame's final data beat carries last

`timescale 1ns/1ps
`default_nettype none

module gmii_rx_datapath (
    input  wire logic                 rx_clk,
    input  wire logic                 rx_rst,
    input  wire eth_rx_pkg::gmii_rx_t gmii,
    input  wire eth_rx_pkg::rx_ctrl_t ctrl,
    output eth_rx_pkg::rx_beat_t      beat,
    output logic                      bad_fcs
);

    eth_rx_pkg::byte_t [eth_rx_pkg::fcs_len-1:0] dly; // index 0 is the newest byte
    eth_rx_pkg::byte_t                           hold_data;
    logic                                        hold_valid;
    logic [2:0]                                  fill;
    logic [31:0]                                 crc;
    logic                                        fcs_ok;

    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input eth_rx_pkg::byte_t data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ eth_rx_pkg::crc32_poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign fcs_ok = (crc == eth_rx_pkg::crc32_residue);

    always_ff @(posedge rx_clk) begin
        if (ctrl.frame_start) begin
            crc <= '1;
        end else if (ctrl.byte_en) begin
            crc       <= crc32_byte(crc, gmii.rxd);
            dly       <= {dly[eth_rx_pkg::fcs_len-2:0], gmii.rxd};
            hold_data <= dly[eth_rx_pkg::fcs_len-1]; // oldest byte can no longer be FCS
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            beat       <= '0;
            bad_fcs    <= 1'b0;
            hold_valid <= 1'b0;
            fill       <= '0;
        end else begin
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            beat.user  <= 1'b0;
            bad_fcs    <= 1'b0;
            if (ctrl.frame_start) begin
                hold_valid <= 1'b0;
                fill       <= '0;
            end else if (ctrl.byte_en) begin
                if (fill != 3'(eth_rx_pkg::fcs_len)) begin
                    fill <= fill + 3'd1;
                end else begin
                    hold_valid <= 1'b1;
                    if (hold_valid) begin
                        beat <= '{valid: 1'b1, data: hold_data, last: 1'b0, user: 1'b0};
                    end
                end
            end else if (ctrl.frame_end) begin
                // the held byte is the final data byte, the delay line holds the FCS
                beat       <= '{valid: 1'b1, data: hold_data, last: 1'b1, user: !fcs_ok};
                bad_fcs    <= !fcs_ok;
                hold_valid <= 1'b0;
                fill       <= '0;
            end else if (ctrl.frame_abort) begin
                beat       <= '{valid: 1'b1, data: hold_data, last: 1'b1, user: 1'b1};
                hold_valid <= 1'b0;
                fill       <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== gmii_rx/gmii_rx_fsm.sv ====
// GMII receive frame-state machine
// Follows preamble, SFD and payload on the sampled GMII input and tells the
// datapath which cycles carry payload, end a frame or abort it

`timescale 1ns/1ps
`default_nettype none

module gmii_rx_fsm (
    input  wire logic                 rx_clk,
    input  wire logic                 rx_rst,
    input  wire eth_rx_pkg::gmii_rx_t gmii,
    output eth_rx_pkg::rx_ctrl_t      ctrl,
    output logic                      bad_frame
);

    eth_rx_pkg::rx_state_e state;
    eth_rx_pkg::rx_state_e state_next;
    logic [2:0]            byte_cnt;     // saturates once the minimum length is reached
    logic                  short_frame;

    assign short_frame = byte_cnt < 3'(eth_rx_pkg::fcs_len + 1);

    always_comb begin
        state_next = state;
        ctrl       = '0;
        case (state)
            eth_rx_pkg::st_idle: begin
                if (gmii.dv) begin
                    if (gmii.er) begin
                        state_next = eth_rx_pkg::st_drop;
                    end else if (gmii.rxd == eth_rx_pkg::preamble_byte) begin
                        state_next = eth_rx_pkg::st_preamble;
                    end else if (gmii.rxd == eth_rx_pkg::sfd_byte) begin
                        ctrl.frame_start = 1'b1; // short preamble is still accepted
                        state_next       = eth_rx_pkg::st_payload;
                    end else begin
                        state_next = eth_rx_pkg::st_drop;
                    end
                end
            end
            eth_rx_pkg::st_preamble: begin
                if (!gmii.dv) begin
                    state_next = eth_rx_pkg::st_idle;
                end else if (gmii.er) begin
                    state_next = eth_rx_pkg::st_drop;
                end else if (gmii.rxd == eth_rx_pkg::sfd_byte) begin
                    ctrl.frame_start = 1'b1;
                    state_next       = eth_rx_pkg::st_payload;
                end else if (gmii.rxd != eth_rx_pkg::preamble_byte) begin
                    state_next = eth_rx_pkg::st_drop;
                end
            end
            eth_rx_pkg::st_payload: begin
                if (!gmii.dv) begin
                    ctrl.frame_abort = short_frame; // not even one byte ahead of the FCS
                    ctrl.frame_end   = !short_frame;
                    state_next       = eth_rx_pkg::st_idle;
                end else if (gmii.er) begin
                    ctrl.frame_abort = 1'b1;
                    state_next       = eth_rx_pkg::st_drop;
                end else begin
                    ctrl.byte_en = 1'b1;
                end
            end
            default: begin
                if (!gmii.dv) begin
                    state_next = eth_rx_pkg::st_idle; // drop waits for the carrier to go away
                end
            end
        endcase
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state     <= eth_rx_pkg::st_idle;
            byte_cnt  <= '0;
            bad_frame <= 1'b0;
        end else begin
            state     <= state_next;
            bad_frame <= ctrl.frame_abort; // lines up with the registered last beat
            if (ctrl.frame_start) begin
                byte_cnt <= '0;
            end else if (ctrl.byte_en && short_frame) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/eth_rx_pkg.sv ====
// Ethernet receive MAC shared definitions
// Holds the GMII framing constants, CRC-32 parameters, state and opcode
// enums, and the bundles passed between the receive blocks

`default_nettype none

package eth_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;

    localparam byte_t preamble_byte = 8'h55;
    localparam byte_t sfd_byte      = 8'hd5;

    localparam logic [31:0] crc32_poly_rev = 32'hedb88320;
    localparam logic [31:0] crc32_residue  = 32'hdebb20e3; // register value after data plus good FCS

    localparam logic [15:0] mcf_eth_type = 16'h8808;
    localparam int          fcs_len      = 4;

    typedef enum logic [15:0] {
        opcode_pause = 16'h0001,
        opcode_pfc   = 16'h0101   // recognized but never acted on
    } mcf_opcode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_drop
    } rx_state_e;

    typedef struct packed {
        byte_t rxd;
        logic  dv;
        logic  er;
    } gmii_rx_t;

    typedef struct packed {
        logic frame_start;  // SFD seen this cycle
        logic byte_en;      // rxd holds a payload byte
        logic frame_end;    // dv dropped after a long enough payload
        logic frame_abort;  // er or truncation inside the payload
    } rx_ctrl_t;

    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  last;
        logic  user;
    } rx_beat_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] quanta;
    } pause_cmd_t;

endpackage

`default_nettype wire
